// ==== fir_pkg.sv ====
// shared widths, array types and coefficients of the 47-tap symmetric FIR
// all arithmetic wraps modulo 2^DATA_W, products keep only their low bits
// COEFFS holds the first half of the symmetric response, tap 23 last

package fir_pkg;

	// ********************************************************
	// widths and types
	// ********************************************************

	// sample, folded sum, product and output all share this width
	localparam int DATA_W = 18;

	typedef logic signed [DATA_W-1:0] sample_t;

	// ********************************************************
	// filter geometry
	// ********************************************************

	localparam int N_TAPS = 47;

	// mirror taps share a coefficient, odd centre tap stands alone
	localparam int N_UNIQ = (N_TAPS + 1) / 2;

	// index 0 is the newest sample
	typedef sample_t tap_vec_t [N_TAPS];

	// folded sums and products, one per distinct coefficient
	typedef sample_t uniq_vec_t [N_UNIQ];

	// ********************************************************
	// coefficient table
	// ********************************************************

	// entry j weights taps j and N_TAPS-1-j
	localparam uniq_vec_t COEFFS = '{
		88, 0, -97, -197, -294, -380,
		-447, -490, -504, -481, -420, -319,
		-178, 0, 212, 451, 710, 980,
		1252, 1514, 1756, 1971, 2147, 2278
	};

	// ********************************************************
	// pipeline depth
	// ********************************************************

	// pairwise reduction levels of the adder tree
	localparam int TREE_DEPTH = $clog2(N_UNIQ);

	// delay line + pre-add + multiply + tree, in enabled edges
	localparam int FIR_LATENCY = 3 + TREE_DEPTH;

endpackage

// ==== fir_tap_delay_line.sv ====
// sample shift register, tap 0 holds the newest sample
// shifts only on edges with i_ena high, reset clears every tap

`timescale 1ns/1ps

module fir_tap_delay_line #(
	parameter int N = 47
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_ena,
	input  fir_pkg::sample_t i_sample,
	output fir_pkg::sample_t o_taps [N]
);

	// newest sample in at tap 0, oldest falls off tap N-1
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < N; i++) begin
				o_taps[i] <= '0;
			end
		end else if (i_ena) begin
			o_taps[0] <= i_sample;
			for (int i = 1; i < N; i++) begin
				o_taps[i] <= o_taps[i-1];
			end
		end
	end

endmodule

// ==== fir_symmetric_preadd.sv ====
// folds mirror taps of the symmetric filter into N_UNIQ registered sums
// sums wrap at DATA_W bits, the centre tap passes through unchanged

`timescale 1ns/1ps

module fir_symmetric_preadd (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_ena,
	input  fir_pkg::tap_vec_t  i_taps,
	output fir_pkg::uniq_vec_t o_sums
);

	import fir_pkg::*;

	// number of true mirror pairs
	localparam int N_PAIRS = N_TAPS / 2;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int j = 0; j < N_UNIQ; j++) begin
				o_sums[j] <= '0;
			end
		end else if (i_ena) begin
			// tap j pairs with tap N_TAPS-1-j
			for (int j = 0; j < N_PAIRS; j++) begin
				o_sums[j] <= i_taps[j] + i_taps[N_TAPS-1-j];
			end
			// bye register for the unpaired centre tap
			if (N_TAPS % 2 == 1) begin
				o_sums[N_UNIQ-1] <= i_taps[N_PAIRS];
			end
		end
	end

endmodule

// ==== fir_coeff_mult.sv ====
// one registered multiplier per folded sum, coefficient from COEFFS
// each product is truncated to its low DATA_W bits

`timescale 1ns/1ps

module fir_coeff_mult (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_ena,
	input  fir_pkg::uniq_vec_t i_sums,
	output fir_pkg::uniq_vec_t o_products
);

	import fir_pkg::*;

	// full-width products before truncation
	logic signed [2*DATA_W-1:0] full_products [N_UNIQ];

	always_comb begin
		for (int j = 0; j < N_UNIQ; j++) begin
			full_products[j] = i_sums[j] * COEFFS[j];
		end
	end

	// ********************************************************
	// product registers
	// ********************************************************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int j = 0; j < N_UNIQ; j++) begin
				o_products[j] <= '0;
			end
		end else if (i_ena) begin
			for (int j = 0; j < N_UNIQ; j++) begin
				// keep the low bits only, same as a modulo 2^DATA_W product
				o_products[j] <= full_products[j][DATA_W-1:0];
			end
		end
	end

endmodule

// ==== fir_adder_tree.sv ====
// registered binary adder tree, one register level per pairwise step
// latency is $clog2(N_IN) enabled edges, sums wrap at DATA_W bits
// an odd term at any level is carried up through a bye register

`timescale 1ns/1ps

module fir_adder_tree #(
	parameter int N_IN = 24
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_ena,
	input  fir_pkg::sample_t i_terms [N_IN],
	output fir_pkg::sample_t o_sum
);

	import fir_pkg::*;

	// number of register levels down to a single sum
	localparam int N_LEVELS = $clog2(N_IN);

	// terms entering level l, halved and rounded up per level
	function automatic int level_count(input int n, input int l);
		int c;
		c = n;
		for (int k = 0; k < l; k++) begin
			c = (c + 1) / 2;
		end
		return c;
	endfunction

	// ********************************************************
	// reduction levels
	// ********************************************************

	for (genvar l = 0; l < N_LEVELS; l++) begin : g_level
		localparam int N_CUR = level_count(N_IN, l);
		localparam int N_NXT = (N_CUR + 1) / 2;

		sample_t in_terms [N_CUR];
		sample_t sums     [N_NXT];

		// level 0 reads the products, later levels the level below
		if (l == 0) begin : g_first
			assign in_terms = i_terms;
		end else begin : g_next
			assign in_terms = g_level[l-1].sums;
		end

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				for (int i = 0; i < N_NXT; i++) begin
					sums[i] <= '0;
				end
			end else if (i_ena) begin
				// neighbouring pairs
				for (int i = 0; i < N_CUR / 2; i++) begin
					sums[i] <= in_terms[2*i] + in_terms[2*i+1];
				end
				// bye register for the leftover term
				if (N_CUR % 2 == 1) begin
					sums[N_NXT-1] <= in_terms[N_CUR-1];
				end
			end
		end
	end

	// last level has exactly one sum
	assign o_sum = g_level[N_LEVELS-1].sums[0];

endmodule

// ==== fir_valid_delay.sv ====
// delays the valid tag by DEPTH enabled edges to line up with the data
// DEPTH must be at least 2

`timescale 1ns/1ps

module fir_valid_delay #(
	parameter int DEPTH = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic i_ena,
	input  logic i_valid,
	output logic o_valid
);

	// bit 0 is the most recent tag
	logic [DEPTH-1:0] valid_pipe;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_pipe <= '0;
		end else if (i_ena) begin
			valid_pipe <= {valid_pipe[DEPTH-2:0], i_valid};
		end
	end

	assign o_valid = valid_pipe[DEPTH-1];

endmodule

// ==== fir_filter.sv ====
// pipelined symmetric 47-tap FIR, 18-bit signed samples, wrapping arithmetic
// computes on every edge with i_clk_ena high, i_valid is only a tag
// o_out and o_valid follow i_in and i_valid after FIR_LATENCY enabled edges
// i_clk_ena low freezes every stage, there is no other back-pressure

`timescale 1ns/1ps

module fir_filter (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_clk_ena,
	input  logic             i_valid,
	input  fir_pkg::sample_t i_in,
	output logic             o_valid,
	output fir_pkg::sample_t o_out
);

	import fir_pkg::*;

	// stage outputs
	tap_vec_t  taps;
	uniq_vec_t folded_sums;
	uniq_vec_t products;

	// ********************************************************
	// data path
	// ********************************************************

	// 1 edge, sample history
	fir_tap_delay_line #(
		.N (N_TAPS)
	) i_tap_delay_line (
		.clk      (clk),
		.reset    (reset),
		.i_ena    (i_clk_ena),
		.i_sample (i_in),
		.o_taps   (taps)
	);

	// 1 edge, mirror taps folded
	fir_symmetric_preadd i_symmetric_preadd (
		.clk    (clk),
		.reset  (reset),
		.i_ena  (i_clk_ena),
		.i_taps (taps),
		.o_sums (folded_sums)
	);

	// 1 edge, coefficient products
	fir_coeff_mult i_coeff_mult (
		.clk        (clk),
		.reset      (reset),
		.i_ena      (i_clk_ena),
		.i_sums     (folded_sums),
		.o_products (products)
	);

	// TREE_DEPTH edges down to one sum
	fir_adder_tree #(
		.N_IN (N_UNIQ)
	) i_adder_tree (
		.clk     (clk),
		.reset   (reset),
		.i_ena   (i_clk_ena),
		.i_terms (products),
		.o_sum   (o_out)
	);

	// ********************************************************
	// valid tag
	// ********************************************************

	// same depth as the whole data path
	fir_valid_delay #(
		.DEPTH (FIR_LATENCY)
	) i_valid_delay (
		.clk     (clk),
		.reset   (reset),
		.i_ena   (i_clk_ena),
		.i_valid (i_valid),
		.o_valid (o_valid)
	);

endmodule

// ==== tb_fir_model.svh ====
// reference model, random numbers and compare tasks for the FIR testbench
// included inside the testbench module body, after the fir_pkg import
// expected outputs sit in queues that advance on enabled edges only

`ifndef TB_FIR_MODEL_SVH
`define TB_FIR_MODEL_SVH

// ************************************************************
// random numbers
// ************************************************************

logic [31:0] lcg_state = 32'ha841_1d69;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// upper bits of the state have the longest period
function automatic sample_t random_sample();
	logic [31:0] r;
	r = lcg_next();
	return sample_t'(r[31:14]);
endfunction

// ************************************************************
// reference model
// ************************************************************

// index 0 is the newest sample
sample_t model_hist [N_TAPS];
sample_t exp_out_q [$];
logic    exp_valid_q [$];

// front of each queue is what the DUT shows right now
function automatic void model_reset();
	exp_out_q.delete();
	exp_valid_q.delete();
	for (int j = 0; j < N_TAPS; j++) begin
		model_hist[j] = '0;
	end
	for (int i = 0; i < FIR_LATENCY; i++) begin
		exp_out_q.push_back('0);
		exp_valid_q.push_back(1'b0);
	end
endfunction

// direct form sum over the whole window, wrapped to DATA_W bits
function automatic sample_t reference_output();
	sample_t                    acc;
	logic signed [2*DATA_W-1:0] prod;
	int                         k;
	acc = '0;
	for (int j = 0; j < N_TAPS; j++) begin
		// mirror taps share one coefficient
		k = (j < N_TAPS - 1 - j) ? j : N_TAPS - 1 - j;
		prod = COEFFS[k] * model_hist[j];
		acc = acc + prod[DATA_W-1:0];
	end
	return acc;
endfunction

// one enabled edge
function automatic void model_step(input logic valid, input sample_t data);
	for (int j = N_TAPS - 1; j > 0; j--) begin
		model_hist[j] = model_hist[j-1];
	end
	model_hist[0] = data;
	exp_out_q.push_back(reference_output());
	exp_valid_q.push_back(valid);
	// the value shown before this edge is gone now
	void'(exp_out_q.pop_front());
	void'(exp_valid_q.pop_front());
endfunction

// ************************************************************
// compare tasks
// ************************************************************

task automatic check_sample(input string name, input sample_t actual, input sample_t expected);
	if (actual !== expected) begin
		$display("[ERROR] %0t: %s is %0d, expected %0d", $time, name, actual, expected);
		$display("Simulation failed");
		$fatal(1);
	end
endtask

task automatic check_valid(input string name, input logic actual, input logic expected);
	if (actual !== expected) begin
		$display("[ERROR] %0t: %s is %b, expected %b", $time, name, actual, expected);
		$display("Simulation failed");
		$fatal(1);
	end
endtask

`endif

// ==== tb_fir_filter.sv ====
// directed tests of the 47-tap FIR against a behavioural model
// inputs change at the rising edge, outputs are checked at the falling edge
// the run stops at the first mismatch or at the cycle limit

`timescale 1ns/1ps

module tb_fir_filter;

	import fir_pkg::*;

	logic    clk;
	logic    reset;
	logic    i_clk_ena;
	logic    i_valid;
	sample_t i_in;
	logic    o_valid;
	sample_t o_out;

	`include "tb_fir_model.svh"

	localparam int RESET_CYCLES = 5;
	localparam int N_RANDOM     = 200;
	localparam int ENA_ROUNDS   = 120;

	// worst case cycles per test
	localparam int RESET_LEN   = RESET_CYCLES + 16;
	localparam int IMPULSE_LEN = N_TAPS + FIR_LATENCY + 4;
	localparam int STREAM_LEN  = N_RANDOM + FIR_LATENCY;
	localparam int ENA_LEN     = ENA_ROUNDS * 9 + FIR_LATENCY;
	localparam int VALID_LEN   = N_RANDOM + FIR_LATENCY;
	localparam int MAX_CYCLES  =
		2 * (RESET_LEN + IMPULSE_LEN + STREAM_LEN + ENA_LEN + VALID_LEN);

	int cycle_count = 0;

	fir_filter i_fir_filter (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", cycle_count);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	// ************************************************************
	// cycle helpers, called right after a rising edge
	// ************************************************************

	task automatic drive_inputs(input logic ena, input logic valid, input sample_t data);
		i_clk_ena <= ena;
		i_valid   <= valid;
		i_in      <= data;
	endtask

	task automatic check_outputs();
		check_sample("o_out", o_out, exp_out_q[0]);
		check_valid("o_valid", o_valid, exp_valid_q[0]);
	endtask

	// model follows the edge that takes these inputs
	task automatic run_cycle(input logic ena, input logic valid, input sample_t data);
		drive_inputs(ena, valid, data);
		@(negedge clk);
		check_outputs();
		@(posedge clk);
		if (ena) begin
			model_step(valid, data);
		end
	endtask

	task automatic flush_pipeline();
		repeat (FIR_LATENCY) run_cycle(1'b1, 1'b0, '0);
	endtask

	// ************************************************************
	// tests
	// ************************************************************

	task automatic test_reset();
		model_reset();
		// first edge under reset already passed
		for (int i = 1; i < RESET_CYCLES; i++) begin
			drive_inputs(1'b1, 1'b0, '0);
			@(negedge clk);
			check_sample("o_out", o_out, '0);
			check_valid("o_valid", o_valid, 1'b0);
			@(posedge clk);
		end
		reset <= 1'b0;
		repeat (16) run_cycle(1'b1, 1'b0, '0);
	endtask

	// history is all zero after the reset test
	task automatic test_impulse();
		sample_t data;
		sample_t want;
		int      j;
		for (int i = 0; i < IMPULSE_LEN; i++) begin
			data = (i == 0) ? sample_t'(1) : sample_t'(0);
			drive_inputs(1'b1, i == 0, data);
			@(negedge clk);
			check_outputs();
			// i enabled edges since the impulse was taken
			j = i - FIR_LATENCY;
			want = '0;
			if (j >= 0 && j < N_TAPS) begin
				want = COEFFS[(j < N_UNIQ) ? j : N_TAPS - 1 - j];
			end
			check_sample("o_out", o_out, want);
			check_valid("o_valid", o_valid, i == FIR_LATENCY);
			@(posedge clk);
			model_step(i == 0, data);
		end
	endtask

	task automatic test_stream();
		for (int i = 0; i < N_RANDOM; i++) begin
			run_cycle(1'b1, 1'b1, random_sample());
		end
		flush_pipeline();
	endtask

	// expected values stand still while disabled
	task automatic test_clock_enable();
		logic [31:0] r;
		int          stretch;
		for (int i = 0; i < ENA_ROUNDS; i++) begin
			r = lcg_next();
			if (r[31:28] < 4'd4) begin
				stretch = 1 + r[27:25];
				for (int k = 0; k < stretch; k++) begin
					// junk on the inputs must not get in
					run_cycle(1'b0, r[24], random_sample());
				end
			end
			run_cycle(1'b1, 1'b1, random_sample());
		end
		flush_pipeline();
	endtask

	task automatic test_valid_pattern();
		logic [31:0] r;
		for (int i = 0; i < N_RANDOM; i++) begin
			r = lcg_next();
			run_cycle(1'b1, r[31], random_sample());
		end
		flush_pipeline();
	endtask

	initial begin
		reset     = 1'b1;
		i_clk_ena = 1'b1;
		i_valid   = 1'b0;
		i_in      = '0;
		@(posedge clk);
		test_reset();
		test_impulse();
		test_stream();
		test_clock_enable();
		test_valid_pattern();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== fir_filter.f ====
+incdir+.
fir_pkg.sv
fir_tap_delay_line.sv
fir_symmetric_preadd.sv
fir_coeff_mult.sv
fir_adder_tree.sv
fir_valid_delay.sv
fir_filter.sv
tb_fir_filter.sv
